//--- sources.f
logic/ctrlPkg.sv
logic/instrDecoder.sv
logic/phaseSequencer.sv
logic/controlWordGen.sv
logic/controlUnit.sv
dv/tbClockGen.sv
dv/controlUnitTb.sv

//--- Bender.yml
package:
  name: control_unit

sources:
  - logic/ctrlPkg.sv
  - logic/instrDecoder.sv
  - logic/phaseSequencer.sv
  - logic/controlWordGen.sv
  - logic/controlUnit.sv
  - target: simulation
    files:
      - dv/tbClockGen.sv
      - dv/controlUnitTb.sv

//--- dv/controlUnitTb.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnitTb;
    import ctrlPkg::*;

    localparam int clockPeriodNs  = 20;
    localparam int resetCycles    = 16;
    localparam int numInstr       = 200;
    localparam int trapHold       = 2;
    localparam int watchdogCycles = numInstr * 12 + 4 * resetCycles;

    logic               clk;
    logic               reset;
    logic               restart;
    logic [opWidth-1:0] opcode;
    logic [opWidth-1:0] funct;
    logic               overflow;
    aluOp_t             aluControl;
    logic [1:0]         aluSrcA;
    logic [1:0]         aluSrcB;
    logic               aluOutControl;
    shiftOp_t           shiftControl;
    logic               shiftSrc;
    logic               shiftAmt;
    logic               regWrite;
    logic [2:0]         regDst;
    logic [3:0]         regData;
    logic               irWrite;
    logic               pcWrite;
    logic               aControl;
    logic               bControl;
    logic               seControl;
    logic               resetOut;

    // expected word for the step executed at the last edge
    logic [2:0] expAluControl;
    logic [1:0] expAluSrcA;
    logic [1:0] expAluSrcB;
    logic       expAluOutControl;
    logic [2:0] expShiftControl;
    logic       expShiftSrc;
    logic       expShiftAmt;
    logic       expRegWrite;
    logic [2:0] expRegDst;
    logic [3:0] expRegData;
    logic       expIrWrite;
    logic       expPcWrite;
    logic       expAControl;
    logic       expBControl;
    logic       expSeControl;
    logic       expResetOut;
    logic       checkSrc;
    logic       expValid;

    // instruction picked for the next decode
    logic [opWidth-1:0] curOp;
    logic [opWidth-1:0] curFn;
    instrClass_t        curClass;
    aluOp_t             curAluOp;
    shiftOp_t           curShiftOp;
    logic               curByShamt;
    logic               curOverflow;
    logic               trapped;

    logic [15:0] lfsrState;
    int          checkCount;
    int          mismatchCount;
    int          failCount;
    int          instrCount;
    int          trapCount;

    tbClockGen #(
        .periodNs   (clockPeriodNs),
        .resetCycles(resetCycles)
    ) u_clockGen (
        .restart(restart),
        .clk    (clk),
        .reset  (reset)
    );

    controlUnit u_dut (
        .clk          (clk),
        .reset        (reset),
        .opcode       (opcode),
        .funct        (funct),
        .overflow     (overflow),
        .aluControl   (aluControl),
        .aluSrcA      (aluSrcA),
        .aluSrcB      (aluSrcB),
        .aluOutControl(aluOutControl),
        .shiftControl (shiftControl),
        .shiftSrc     (shiftSrc),
        .shiftAmt     (shiftAmt),
        .regWrite     (regWrite),
        .regDst       (regDst),
        .regData      (regData),
        .irWrite      (irWrite),
        .pcWrite      (pcWrite),
        .aControl     (aControl),
        .bControl     (bControl),
        .seControl    (seControl),
        .resetOut     (resetOut)
    );

    // galois LFSR stepped once per bit taken
    function automatic logic [7:0] takeBits(input int count);
        logic [7:0] bits;
        int         i;
        bits = '0;
        for (i = 0; i < count; i++) begin
            bits      = {bits[6:0], lfsrState[0]};
            lfsrState = (lfsrState >> 1) ^ (lfsrState[0] ? 16'hB400 : 16'h0000);
        end
        return bits;
    endfunction

    task automatic setInstr(input logic [opWidth-1:0] op, input logic [opWidth-1:0] fn,
                            input instrClass_t cls, input aluOp_t aOp, input shiftOp_t sOp,
                            input logic byShamt);
        curOp      = op;
        curFn      = fn;
        curClass   = cls;
        curAluOp   = aOp;
        curShiftOp = sOp;
        curByShamt = byShamt;
    endtask

    task automatic pickInstruction();
        logic [3:0]         sel;
        logic [7:0]         ovfBits;
        logic [opWidth-1:0] fieldBits;
        sel       = 4'(takeBits(4) % 13);
        fieldBits = 6'(takeBits(6));
        case (sel)
            4'd0: setInstr(opRType, fnAdd, clsAluR, aluAdd, shNop, 1'b0);
            4'd1: setInstr(opRType, fnSub, clsAluR, aluSub, shNop, 1'b0);
            4'd2: setInstr(opRType, fnAnd, clsAluR, aluAnd, shNop, 1'b0);
            4'd3: setInstr(opRType, fnSll, clsShift, aluPass, shLeft, 1'b1);
            4'd4: setInstr(opRType, fnSrl, clsShift, aluPass, shRightLogic, 1'b1);
            4'd5: setInstr(opRType, fnSra, clsShift, aluPass, shRightArith, 1'b1);
            4'd6: setInstr(opRType, fnSllv, clsShift, aluPass, shLeft, 1'b0);
            4'd7: setInstr(opRType, fnSrav, clsShift, aluPass, shRightArith, 1'b0);
            4'd8: setInstr(opRType, fnJr, clsJr, aluPass, shNop, 1'b0);
            4'd9: setInstr(opAddi, fieldBits, clsAddi, aluAdd, shNop, 1'b0);
            4'd10: setInstr(opLui, fieldBits, clsLui, aluSub, shNop, 1'b0);
            // div is not supported
            4'd11: setInstr(opRType, 6'b011010, clsNone, aluPass, shNop, 1'b0);
            default: setInstr(6'b100011, fieldBits, clsNone, aluPass, shNop, 1'b0);
        endcase
        ovfBits     = takeBits(2);
        curOverflow = &ovfBits[1:0];
    endtask

    task automatic clearExpected();
        expAluControl    = aluPass;
        expAluSrcA       = srcAPc;
        expAluSrcB       = srcBReg;
        expAluOutControl = 1'b0;
        expShiftControl  = shNop;
        expShiftSrc      = 1'b0;
        expShiftAmt      = 1'b0;
        expRegWrite      = 1'b0;
        expRegDst        = dstRt;
        expRegData       = dataAluOut;
        expIrWrite       = 1'b0;
        expPcWrite       = 1'b0;
        expAControl      = 1'b0;
        expBControl      = 1'b0;
        expSeControl     = 1'b0;
        expResetOut      = 1'b0;
        checkSrc         = 1'b1;
        expValid         = 1'b1;
    endtask

    task automatic compareField(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
        checkCount++;
        assert (got === expected) else begin
            mismatchCount++;
            $display("MISMATCH t=%0t %s expected=%0h got=%0h", $time, name, expected, got);
        end
    endtask

    task automatic checkOutputs();
        if (expValid) begin
            compareField("aluControl", 32'(aluControl), 32'(expAluControl));
            if (checkSrc) begin
                compareField("aluSrcA", 32'(aluSrcA), 32'(expAluSrcA));
                compareField("aluSrcB", 32'(aluSrcB), 32'(expAluSrcB));
            end
            compareField("aluOutControl", 32'(aluOutControl), 32'(expAluOutControl));
            compareField("shiftControl", 32'(shiftControl), 32'(expShiftControl));
            compareField("shiftSrc", 32'(shiftSrc), 32'(expShiftSrc));
            compareField("shiftAmt", 32'(shiftAmt), 32'(expShiftAmt));
            compareField("regWrite", 32'(regWrite), 32'(expRegWrite));
            compareField("regDst", 32'(regDst), 32'(expRegDst));
            compareField("regData", 32'(regData), 32'(expRegData));
            compareField("irWrite", 32'(irWrite), 32'(expIrWrite));
            compareField("pcWrite", 32'(pcWrite), 32'(expPcWrite));
            compareField("aControl", 32'(aControl), 32'(expAControl));
            compareField("bControl", 32'(bControl), 32'(expBControl));
            compareField("seControl", 32'(seControl), 32'(expSeControl));
            compareField("resetOut", 32'(resetOut), 32'(expResetOut));
        end
    endtask

    // outputs seen here belong to the step of the previous edge
    task automatic nextEdge();
        @(posedge clk);
        checkOutputs();
    endtask

    task automatic expectResetWord();
        clearExpected();
        expResetOut = 1'b1;
        expRegWrite = 1'b1;
        expRegDst   = dstSp;
        expRegData  = dataSpInit;
    endtask

    // returns on the first edge with reset low, which runs fetch step 0
    task automatic sitThroughReset();
        int guard;
        guard = 0;
        nextEdge();
        while (reset && guard < 4 * resetCycles) begin
            expectResetWord();
            nextEdge();
            guard++;
        end
        assert (!reset) else begin
            failCount++;
            $display("reset was still high after %0d cycles", guard);
        end
    endtask

    task automatic runInstruction();
        int s;
        for (s = 0; s < fetchSteps; s++) begin
            clearExpected();
            expAluControl = aluAdd;
            expAluSrcB    = srcBFour;
            if (s == fetchSteps - 1) begin
                expIrWrite = 1'b1;
                expPcWrite = 1'b1;
            end
            nextEdge();
        end
        // the irWrite pulse was just checked so the next word goes on the bus
        pickInstruction();
        opcode   <= curOp;
        funct    <= curFn;
        overflow <= curOverflow;
        for (s = 0; s < decodeSteps; s++) begin
            clearExpected();
            expAControl      = 1'b1;
            expBControl      = 1'b1;
            expSeControl     = 1'b1;
            expAluOutControl = 1'b1;
            expAluControl    = aluAdd;
            expAluSrcB       = srcBBranch;
            nextEdge();
        end
        case (curClass)
            clsAluR, clsAddi: begin
                clearExpected();
                checkSrc         = 1'b0;
                expAluControl    = curAluOp;
                expAluOutControl = 1'b1;
                nextEdge();
                clearExpected();
                checkSrc = 1'b0;
                if (!curOverflow) begin
                    expRegWrite = 1'b1;
                    expRegDst   = (curClass == clsAddi) ? dstRt : dstRd;
                    expRegData  = dataAluOut;
                end
                nextEdge();
                trapped = curOverflow;
            end
            clsShift: begin
                for (s = 0; s < shiftSteps; s++) begin
                    clearExpected();
                    expShiftSrc = curByShamt;
                    expShiftAmt = curByShamt;
                    if (s < 2) begin
                        expShiftControl = shLoad;
                    end else if (s == 2) begin
                        expShiftControl = curShiftOp;
                    end else begin
                        expRegWrite = 1'b1;
                        expRegDst   = dstRd;
                        expRegData  = dataShift;
                    end
                    nextEdge();
                end
            end
            clsJr, clsLui: begin
                clearExpected();
                checkSrc      = 1'b0;
                expPcWrite    = 1'b1;
                expAluControl = curAluOp;
                nextEdge();
            end
            default: begin
                clearExpected();
                nextEdge();
            end
        endcase
        instrCount++;
    endtask

    // trap holds with all outputs low until a fresh reset
    task automatic recoverFromTrap();
        int i;
        trapCount++;
        for (i = 0; i < trapHold; i++) begin
            clearExpected();
            nextEdge();
        end
        clearExpected();
        restart <= 1'b1;
        nextEdge();
        restart <= 1'b0;
        // reset rises on this edge while the DUT still sees it low
        clearExpected();
        sitThroughReset();
    endtask

    task automatic finishRun();
        $display("instructions=%0d traps=%0d checks=%0d mismatches=%0d failures=%0d",
                 instrCount, trapCount, checkCount, mismatchCount, failCount);
        if (mismatchCount == 0 && failCount == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    initial begin
        lfsrState     = 16'd85;
        opcode        = opRType;
        funct         = fnAdd;
        overflow      = 1'b0;
        restart       = 1'b0;
        expValid      = 1'b0;
        checkSrc      = 1'b1;
        trapped       = 1'b0;
        checkCount    = 0;
        mismatchCount = 0;
        failCount     = 0;
        instrCount    = 0;
        trapCount     = 0;
        sitThroughReset();
        repeat (numInstr) begin
            trapped = 1'b0;
            runInstruction();
            if (trapped) begin
                recoverFromTrap();
            end
        end
        finishRun();
    end

    initial begin
        #(watchdogCycles * clockPeriodNs);
        failCount++;
        $display("watchdog expired after %0d cycles", watchdogCycles);
        finishRun();
    end

endmodule

`default_nettype wire

//--- dv/tbClockGen.sv
`timescale 1ns/1ps
`default_nettype none

module tbClockGen #(
    parameter int periodNs    = 20,
    parameter int resetCycles = 16
) (
    input  logic restart,
    output logic clk,
    output logic reset
);
    int resetLeft;

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        resetLeft = resetCycles;
        forever begin
            #(periodNs / 2);
            clk = ~clk;
        end
    end

    // counts reset edges down and reloads the count on restart
    always @(posedge clk) begin
        if (restart) begin
            reset     <= 1'b1;
            resetLeft <= resetCycles;
        end else if (resetLeft > 0) begin
            resetLeft <= resetLeft - 1;
            if (resetLeft == 1) begin
                reset <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [ctrlPkg::opWidth-1:0] opcode,
    input  logic [ctrlPkg::opWidth-1:0] funct,
    input  logic                        overflow,
    output ctrlPkg::aluOp_t             aluControl,
    output logic [1:0]                  aluSrcA,
    output logic [1:0]                  aluSrcB,
    output logic                        aluOutControl,
    output ctrlPkg::shiftOp_t           shiftControl,
    output logic                        shiftSrc,
    output logic                        shiftAmt,
    output logic                        regWrite,
    output logic [2:0]                  regDst,
    output logic [3:0]                  regData,
    output logic                        irWrite,
    output logic                        pcWrite,
    output logic                        aControl,
    output logic                        bControl,
    output logic                        seControl,
    output logic                        resetOut
);
    import ctrlPkg::*;

    instrClass_t          instrClass;
    aluOp_t               aluOp;
    shiftOp_t             shiftOp;
    logic                 shiftByShamt;
    ctrlState_t           state;
    logic [stepWidth-1:0] step;

    instrDecoder u_decoder (
        .opcode      (opcode),
        .funct       (funct),
        .instrClass  (instrClass),
        .aluOp       (aluOp),
        .shiftOp     (shiftOp),
        .shiftByShamt(shiftByShamt)
    );

    phaseSequencer u_sequencer (
        .clk       (clk),
        .reset     (reset),
        .instrClass(instrClass),
        .overflow  (overflow),
        .state     (state),
        .step      (step)
    );

    controlWordGen u_wordGen (
        .clk          (clk),
        .reset        (reset),
        .state        (state),
        .step         (step),
        .instrClass   (instrClass),
        .aluOp        (aluOp),
        .shiftOp      (shiftOp),
        .shiftByShamt (shiftByShamt),
        .overflow     (overflow),
        .aluControl   (aluControl),
        .aluSrcA      (aluSrcA),
        .aluSrcB      (aluSrcB),
        .aluOutControl(aluOutControl),
        .shiftControl (shiftControl),
        .shiftSrc     (shiftSrc),
        .shiftAmt     (shiftAmt),
        .regWrite     (regWrite),
        .regDst       (regDst),
        .regData      (regData),
        .irWrite      (irWrite),
        .pcWrite      (pcWrite),
        .aControl     (aControl),
        .bControl     (bControl),
        .seControl    (seControl),
        .resetOut     (resetOut)
    );

endmodule

`default_nettype wire

//--- logic/controlWordGen.sv
`timescale 1ns/1ps
`default_nettype none

module controlWordGen (
    input  logic                            clk,
    input  logic                            reset,
    input  ctrlPkg::ctrlState_t             state,
    input  logic [ctrlPkg::stepWidth-1:0]   step,
    input  ctrlPkg::instrClass_t            instrClass,
    input  ctrlPkg::aluOp_t                 aluOp,
    input  ctrlPkg::shiftOp_t               shiftOp,
    input  logic                            shiftByShamt,
    input  logic                            overflow,
    output ctrlPkg::aluOp_t                 aluControl,
    output logic [1:0]                      aluSrcA,
    output logic [1:0]                      aluSrcB,
    output logic                            aluOutControl,
    output ctrlPkg::shiftOp_t               shiftControl,
    output logic                            shiftSrc,
    output logic                            shiftAmt,
    output logic                            regWrite,
    output logic [2:0]                      regDst,
    output logic [3:0]                      regData,
    output logic                            irWrite,
    output logic                            pcWrite,
    output logic                            aControl,
    output logic                            bControl,
    output logic                            seControl,
    output logic                            resetOut
);
    import ctrlPkg::*;

    always_ff @(posedge clk) begin
        aluControl    <= aluPass;
        aluSrcA       <= srcAPc;
        aluSrcB       <= srcBReg;
        aluOutControl <= 1'b0;
        shiftControl  <= shNop;
        shiftSrc      <= 1'b0;
        shiftAmt      <= 1'b0;
        regWrite      <= 1'b0;
        regDst        <= dstRt;
        regData       <= dataAluOut;
        irWrite       <= 1'b0;
        pcWrite       <= 1'b0;
        aControl      <= 1'b0;
        bControl      <= 1'b0;
        seControl     <= 1'b0;
        resetOut      <= 1'b0;

        if (reset) begin
            // load the stack pointer
            resetOut <= 1'b1;
            regWrite <= 1'b1;
            regDst   <= dstSp;
            regData  <= dataSpInit;
        end else begin
            unique case (state)
                stResetInit, stFetch: begin
                    aluControl <= aluAdd;
                    aluSrcB    <= srcBFour;
                    if (step == stepWidth'(fetchSteps - 1)) begin
                        irWrite <= 1'b1;
                        pcWrite <= 1'b1;
                    end
                end
                stDecode: begin
                    aControl      <= 1'b1;
                    bControl      <= 1'b1;
                    seControl     <= 1'b1;
                    aluOutControl <= 1'b1;
                    aluControl    <= aluAdd;
                    aluSrcB       <= srcBBranch;
                end
                stExecR, stExecI: begin
                    unique case (instrClass)
                        clsAluR, clsAddi: begin
                            aluSrcA <= srcAReg;
                            aluSrcB <= (instrClass == clsAddi) ? srcBImm : srcBReg;
                            if (step == '0) begin
                                aluControl    <= aluOp;
                                aluOutControl <= 1'b1;
                            end else if (!overflow) begin
                                // overflowed results are never written back
                                regWrite <= 1'b1;
                                regDst   <= (instrClass == clsAddi) ? dstRt : dstRd;
                                regData  <= dataAluOut;
                            end
                        end
                        clsShift: begin
                            shiftSrc <= shiftByShamt;
                            shiftAmt <= shiftByShamt;
                            if (step < 2'd2) begin
                                shiftControl <= shLoad;
                            end else if (step == 2'd2) begin
                                shiftControl <= shiftOp;
                            end else begin
                                regWrite <= 1'b1;
                                regDst   <= dstRd;
                                regData  <= dataShift;
                            end
                        end
                        clsJr: begin
                            aluSrcA    <= srcAReg;
                            aluControl <= aluPass;
                            pcWrite    <= 1'b1;
                        end
                        clsLui: begin
                            aluSrcB    <= srcBFour;
                            aluControl <= aluSub;
                            pcWrite    <= 1'b1;
                        end
                        default: begin
                        end
                    endcase
                end
                default: begin
                end
            endcase
        end
    end

    noWriteOnFetch: assert property (@(posedge clk) disable iff (reset)
        !(regWrite && irWrite));

endmodule

`default_nettype wire

//--- logic/phaseSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module phaseSequencer (
    input  logic                            clk,
    input  logic                            reset,
    input  ctrlPkg::instrClass_t            instrClass,
    input  logic                            overflow,
    output ctrlPkg::ctrlState_t             state,
    output logic [ctrlPkg::stepWidth-1:0]   step
);
    import ctrlPkg::*;

    logic [stepWidth-1:0] phaseLast;
    logic                 isRFormat;
    logic                 checksOverflow;

    assign isRFormat      = (instrClass == clsAluR) || (instrClass == clsShift)
                            || (instrClass == clsJr);
    assign checksOverflow = (instrClass == clsAluR) || (instrClass == clsAddi);

    // last step index of the phase in progress
    always_comb begin
        unique case (state)
            stResetInit, stFetch: phaseLast = stepWidth'(fetchSteps - 1);
            stDecode:             phaseLast = stepWidth'(decodeSteps - 1);
            stExecR, stExecI: begin
                unique case (instrClass)
                    clsAluR, clsAddi: phaseLast = stepWidth'(aluSteps - 1);
                    clsShift:         phaseLast = stepWidth'(shiftSteps - 1);
                    default:          phaseLast = '0;
                endcase
            end
            default: phaseLast = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= stResetInit;
            step  <= '0;
        end else if (state != stTrap) begin
            if (step != phaseLast) begin
                step <= step + 1'b1;
                // reset-init doubles as fetch step 0
                if (state == stResetInit) begin
                    state <= stFetch;
                end
            end else begin
                step <= '0;
                unique case (state)
                    stResetInit, stFetch: state <= stDecode;
                    stDecode:             state <= isRFormat ? stExecR : stExecI;
                    default: begin
                        if (checksOverflow && overflow) begin
                            state <= stTrap;
                        end else begin
                            state <= stFetch;
                        end
                    end
                endcase
            end
        end
    end

    stepInPhase: assert property (@(posedge clk) disable iff (reset)
        step <= phaseLast);

    // trap is sticky until the next reset
    trapHeld: assert property (@(posedge clk) disable iff (reset)
        (state == stTrap) |=> (state == stTrap));

endmodule

`default_nettype wire

//--- logic/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
    input  logic [ctrlPkg::opWidth-1:0] opcode,
    input  logic [ctrlPkg::opWidth-1:0] funct,
    output ctrlPkg::instrClass_t        instrClass,
    output ctrlPkg::aluOp_t             aluOp,
    output ctrlPkg::shiftOp_t           shiftOp,
    output logic                        shiftByShamt
);
    import ctrlPkg::*;

    always_comb begin
        instrClass   = clsNone;
        aluOp        = aluPass;
        shiftOp      = shNop;
        shiftByShamt = 1'b0;

        unique case (opcode)
            opRType: begin
                unique case (funct)
                    fnAdd: begin
                        instrClass = clsAluR;
                        aluOp      = aluAdd;
                    end
                    fnSub: begin
                        instrClass = clsAluR;
                        aluOp      = aluSub;
                    end
                    fnAnd: begin
                        instrClass = clsAluR;
                        aluOp      = aluAnd;
                    end
                    fnSll, fnSllv: begin
                        instrClass   = clsShift;
                        shiftOp      = shLeft;
                        shiftByShamt = (funct == fnSll);
                    end
                    fnSrl: begin
                        instrClass   = clsShift;
                        shiftOp      = shRightLogic;
                        shiftByShamt = 1'b1;
                    end
                    fnSra, fnSrav: begin
                        instrClass   = clsShift;
                        shiftOp      = shRightArith;
                        shiftByShamt = (funct == fnSra);
                    end
                    fnJr: instrClass = clsJr;
                    default: instrClass = clsNone;
                endcase
            end
            opAddi: begin
                instrClass = clsAddi;
                aluOp      = aluAdd;
            end
            // upper immediate goes through the ALU as a subtract
            opLui: begin
                instrClass = clsLui;
                aluOp      = aluSub;
            end
            default: instrClass = clsNone;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/ctrlPkg.sv
`default_nettype none

package ctrlPkg;

    localparam int opWidth = 6;

    // opcodes
    localparam logic [opWidth-1:0] opRType = 6'b000000;
    localparam logic [opWidth-1:0] opAddi  = 6'b001000;
    localparam logic [opWidth-1:0] opLui   = 6'b001111;

    // R-format function codes
    localparam logic [opWidth-1:0] fnAdd  = 6'b100000;
    localparam logic [opWidth-1:0] fnSub  = 6'b100010;
    localparam logic [opWidth-1:0] fnAnd  = 6'b100100;
    localparam logic [opWidth-1:0] fnSll  = 6'b000000;
    localparam logic [opWidth-1:0] fnSrl  = 6'b000010;
    localparam logic [opWidth-1:0] fnSra  = 6'b000011;
    localparam logic [opWidth-1:0] fnSllv = 6'b000100;
    localparam logic [opWidth-1:0] fnSrav = 6'b000111;
    localparam logic [opWidth-1:0] fnJr   = 6'b001000;

    typedef enum logic [2:0] {
        stResetInit,
        stFetch,
        stDecode,
        stExecR,
        stExecI,
        stTrap
    } ctrlState_t;

    typedef enum logic [2:0] {
        clsAluR,
        clsShift,
        clsJr,
        clsAddi,
        clsLui,
        clsNone
    } instrClass_t;

    typedef enum logic [2:0] {
        aluPass = 3'b000,
        aluAdd  = 3'b001,
        aluSub  = 3'b010,
        aluAnd  = 3'b011
    } aluOp_t;

    typedef enum logic [2:0] {
        shNop        = 3'b000,
        shLoad       = 3'b001,
        shLeft       = 3'b010,
        shRightLogic = 3'b011,
        shRightArith = 3'b100
    } shiftOp_t;

    // register file write port selects
    localparam logic [2:0] dstRt = 3'b000;
    localparam logic [2:0] dstRd = 3'b001;
    localparam logic [2:0] dstSp = 3'b010;

    localparam logic [3:0] dataAluOut = 4'b0000;
    localparam logic [3:0] dataShift  = 4'b0111;
    localparam logic [3:0] dataSpInit = 4'b1000;

    // ALU operand muxes
    localparam logic [1:0] srcAPc     = 2'b00;
    localparam logic [1:0] srcAReg    = 2'b01;
    localparam logic [1:0] srcBReg    = 2'b00;
    localparam logic [1:0] srcBFour   = 2'b01;
    localparam logic [1:0] srcBImm    = 2'b10;
    localparam logic [1:0] srcBBranch = 2'b11;

    // phase lengths in edges
    localparam int unsigned fetchSteps  = 3;
    localparam int unsigned decodeSteps = 2;
    localparam int unsigned aluSteps    = 2;
    localparam int unsigned shiftSteps  = 4;

    localparam int stepWidth = 2;

endpackage

`default_nettype wire
